// File: Makefile
TOOL      := verilator
FLAGS     := --timing
TOP       := tb_dram_bridge
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/app_cmd_issuer.sv
// Drains the request queue onto the controller application interface.
// Command and write data are accepted separately, in either order.
`timescale 1ns/10ps

module app_cmd_issuer (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_req_empty,
    input  logic [bridge_user_pkg::REQ_W-1:0]     i_req_data,
    input  logic                                  i_app_rdy,
    input  logic                                  i_app_wdf_rdy,
    output logic                                  o_req_pop,
    output logic                                  o_app_en,
    output logic [bridge_app_pkg::APP_CMD_W-1:0]  o_app_cmd,
    output logic [bridge_app_pkg::APP_ADDR_W-1:0] o_app_addr,
    output logic                                  o_app_wdf_wren,
    output logic [bridge_app_pkg::APP_DATA_W-1:0] o_app_wdf_data,
    output logic [bridge_app_pkg::APP_MASK_W-1:0] o_app_wdf_mask
);

    import bridge_user_pkg::*;
    import bridge_app_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_CMD_DATA = 2'd1;
    localparam logic [1:0] ST_CMD      = 2'd2;
    localparam logic [1:0] ST_DATA     = 2'd3;

    logic [1:0]             state;
    logic [1:0]             state_next;
    logic                   last_done;
    logic                   req_wr;
    logic [USER_ADDR_W-1:0] req_addr;
    logic [USER_DATA_W-1:0] req_data;
    logic [USER_MASK_W-1:0] req_mask;
    app_line_u              line_next;
    app_line_u              line_r;
    logic [APP_MASK_W-1:0]  mask_next;

    // request word fields
    assign req_wr   = i_req_data[REQ_WR_BIT];
    assign req_addr = i_req_data[REQ_WR_BIT-1 -: USER_ADDR_W];
    assign req_data = i_req_data[USER_DATA_W+USER_MASK_W-1 -: USER_DATA_W];
    assign req_mask = i_req_data[USER_MASK_W-1:0];

    // word copied to every lane, user mask only in the addressed lane
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            line_next.lane[i] = req_data;
            if (int'(req_addr[3:2]) == i) begin
                mask_next[i*LANE_MASK_W +: LANE_MASK_W] = req_mask;
            end else begin
                mask_next[i*LANE_MASK_W +: LANE_MASK_W] = '1;
            end
        end
    end

    always_comb begin
        last_done  = 1'b0;
        state_next = state;
        case (state)
            ST_IDLE: begin
                last_done = 1'b1;
            end
            ST_CMD_DATA: begin
                if (i_app_rdy && i_app_wdf_rdy) begin
                    last_done = 1'b1;
                end else if (i_app_rdy) begin
                    state_next = ST_DATA;
                end else if (i_app_wdf_rdy) begin
                    state_next = ST_CMD;
                end
            end
            ST_CMD: begin
                last_done = i_app_rdy;
            end
            default: begin
                last_done = i_app_wdf_rdy;
            end
        endcase
        // next request goes out as the last acceptance lands
        if (last_done) begin
            if (!i_req_empty) begin
                state_next = req_wr ? ST_CMD_DATA : ST_CMD;
            end else begin
                state_next = ST_IDLE;
            end
        end
    end

    assign o_req_pop      = last_done && !i_req_empty;
    assign o_app_en       = (state == ST_CMD_DATA) || (state == ST_CMD);
    assign o_app_wdf_wren = (state == ST_CMD_DATA) || (state == ST_DATA);
    assign o_app_wdf_data = line_r.flat;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_pop) begin
            o_app_cmd      <= req_wr ? CMD_WRITE : CMD_READ;
            o_app_addr     <= {{(APP_ADDR_W-26){1'b0}}, req_addr[26:4], 3'b000};
            line_r         <= line_next;
            o_app_wdf_mask <= mask_next;
        end
    end

endmodule

// File: design/bridge_app_pkg.sv
// Application interface of the DDR controller: widths, command codes and
// the 128-bit line type, seen either flat or as four 32-bit lanes.
package bridge_app_pkg;

    localparam int APP_ADDR_W = 28;
    localparam int APP_DATA_W = 128;
    localparam int APP_MASK_W = 16;
    localparam int APP_CMD_W  = 3;

    localparam logic [APP_CMD_W-1:0] CMD_WRITE = 3'd0;
    localparam logic [APP_CMD_W-1:0] CMD_READ  = 3'd1;

    // 32-bit words per line
    localparam int LANES       = 4;
    localparam int LANE_W      = APP_DATA_W / LANES;
    localparam int LANE_MASK_W = APP_MASK_W / LANES;

    typedef union packed {
        logic [APP_DATA_W-1:0]         flat;
        logic [LANES-1:0][LANE_W-1:0]  lane;
    } app_line_u;

endpackage

// File: design/bridge_user_pkg.sv
// Processor-side port widths and the layout of one packed request word.
// Request word, MSB first: write flag, byte address, data word, byte mask.
package bridge_user_pkg;

    localparam int USER_ADDR_W = 32;
    localparam int USER_DATA_W = 32;

    // mask bit set means the byte is left alone
    localparam int USER_MASK_W = 4;

    localparam int REQ_W = 1 + USER_ADDR_W + USER_DATA_W + USER_MASK_W;

    // write flag sits on top of the word
    localparam int REQ_WR_BIT = REQ_W - 1;

endpackage

// File: design/dram_bridge_top.sv
// Bridge from a 32-bit processor port to a DDR controller application port.
// Requests and read lines pass through two queues sized by QUEUE_DEPTH_LOG2.
`timescale 1ns/10ps

module dram_bridge_top #(
    parameter int QUEUE_DEPTH_LOG2 = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_x_async,
    input  logic                                   i_rd_en,
    input  logic                                   i_wr_en,
    input  logic [bridge_user_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [bridge_user_pkg::USER_DATA_W-1:0] i_data,
    input  logic [bridge_user_pkg::USER_MASK_W-1:0] i_mask,
    input  logic                                   i_init_calib_complete,
    input  logic                                   i_app_rdy,
    input  logic                                   i_app_wdf_rdy,
    input  logic [bridge_app_pkg::APP_DATA_W-1:0]  i_app_rd_data,
    input  logic                                   i_app_rd_data_valid,
    output logic                                   o_busy,
    output logic                                   o_init_calib_complete,
    output logic [bridge_app_pkg::APP_DATA_W-1:0]  o_data,
    output logic                                   o_app_en,
    output logic [bridge_app_pkg::APP_CMD_W-1:0]   o_app_cmd,
    output logic [bridge_app_pkg::APP_ADDR_W-1:0]  o_app_addr,
    output logic                                   o_app_wdf_wren,
    output logic                                   o_app_wdf_end,
    output logic [bridge_app_pkg::APP_DATA_W-1:0]  o_app_wdf_data,
    output logic [bridge_app_pkg::APP_MASK_W-1:0]  o_app_wdf_mask
);

    import bridge_user_pkg::*;
    import bridge_app_pkg::*;

    logic                  req_push;
    logic [REQ_W-1:0]      req_data;
    logic [REQ_W-1:0]      req_head;
    logic                  req_pop;
    logic                  req_empty;
    logic                  req_full;
    logic                  resp_pop;
    logic [APP_DATA_W-1:0] resp_head;
    logic                  resp_empty;

    // every write is a single beat
    assign o_app_wdf_end = o_app_wdf_wren;

    user_request_fsm u_user_request_fsm (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_rd_en               (i_rd_en),
        .i_wr_en               (i_wr_en),
        .i_addr                (i_addr),
        .i_data                (i_data),
        .i_mask                (i_mask),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req_full            (req_full),
        .i_resp_empty          (resp_empty),
        .i_resp_data           (resp_head),
        .o_req_push            (req_push),
        .o_req_data            (req_data),
        .o_resp_pop            (resp_pop),
        .o_busy                (o_busy),
        .o_init_calib_complete (o_init_calib_complete),
        .o_data                (o_data)
    );

    sync_fifo #(
        .DATA_W           (REQ_W),
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_req_queue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (req_push),
        .i_data      (req_data),
        .i_pop       (req_pop),
        .o_data      (req_head),
        .o_empty     (req_empty),
        .o_full      (req_full)
    );

    // one read in flight at most, so this queue never fills
    sync_fifo #(
        .DATA_W           (APP_DATA_W),
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_resp_queue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd_data_valid),
        .i_data      (i_app_rd_data),
        .i_pop       (resp_pop),
        .o_data      (resp_head),
        .o_empty     (resp_empty),
        .o_full      ()
    );

    app_cmd_issuer u_app_cmd_issuer (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_req_empty    (req_empty),
        .i_req_data     (req_head),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_req_pop      (req_pop),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_mask (o_app_wdf_mask)
    );

endmodule

// File: design/sync_fifo.sv
// Single-clock FIFO built as a register ring with an occupancy count.
// Push into a full queue or pop from an empty one is ignored.
`timescale 1ns/10ps

module sync_fifo #(
    parameter int DATA_W           = 32,
    parameter int QUEUE_DEPTH_LOG2 = 2
) (
    input  logic              clk,
    input  logic              rst_x_async,
    input  logic              i_push,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_pop,
    output logic [DATA_W-1:0] o_data,
    output logic              o_empty,
    output logic              o_full
);

    localparam int DEPTH = 1 << QUEUE_DEPTH_LOG2;

    logic [DATA_W-1:0]           mem [DEPTH];
    logic [QUEUE_DEPTH_LOG2-1:0] wr_ptr;
    logic [QUEUE_DEPTH_LOG2-1:0] rd_ptr;
    logic [QUEUE_DEPTH_LOG2:0]   count;
    logic                        do_push;
    logic                        do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    // count never exceeds DEPTH, so the top bit alone marks full
    assign o_full  = count[QUEUE_DEPTH_LOG2];
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

// File: design/user_request_fsm.sv
// Processor-side front end: synchronizes calibrate-done, accepts one request
// at a time into the request queue and returns read lines through o_data.
`timescale 1ns/10ps

module user_request_fsm (
    input  logic                                   clk,
    input  logic                                   rst_x_async,
    input  logic                                   i_rd_en,
    input  logic                                   i_wr_en,
    input  logic [bridge_user_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [bridge_user_pkg::USER_DATA_W-1:0] i_data,
    input  logic [bridge_user_pkg::USER_MASK_W-1:0] i_mask,
    input  logic                                   i_init_calib_complete,
    input  logic                                   i_req_full,
    input  logic                                   i_resp_empty,
    input  bridge_app_pkg::app_line_u              i_resp_data,
    output logic                                   o_req_push,
    output logic [bridge_user_pkg::REQ_W-1:0]      o_req_data,
    output logic                                   o_resp_pop,
    output logic                                   o_busy,
    output logic                                   o_init_calib_complete,
    output logic [bridge_app_pkg::APP_DATA_W-1:0]  o_data
);

    import bridge_user_pkg::*;

    localparam logic [1:0] ST_CALIB = 2'd0;
    localparam logic [1:0] ST_IDLE  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_READ  = 2'd3;

    logic [1:0]             state;
    logic                   calib_sync1;
    logic                   calib_sync2;
    logic [USER_MASK_W-1:0] req_mask;

    // two-flop sync of calibrate-done
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_init_calib_complete;
            calib_sync2 <= calib_sync1;
        end
    end

    assign o_init_calib_complete = calib_sync2;

    // write wins over read, reads carry a zero mask
    assign req_mask   = i_wr_en ? i_mask : '0;
    assign o_req_push = (state == ST_IDLE) && (i_wr_en || i_rd_en);
    assign o_req_data = {i_wr_en, i_addr, i_data, req_mask};

    assign o_resp_pop = (state == ST_READ) && !i_resp_empty;
    assign o_busy     = (state != ST_IDLE);

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= ST_CALIB;
        end else begin
            case (state)
                ST_CALIB: begin
                    if (calib_sync2) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (i_wr_en) begin
                        state <= ST_WRITE;
                    end else if (i_rd_en) begin
                        state <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    // done once the queue has room again
                    if (!i_req_full) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (!i_resp_empty) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // line stays until the next read completes
    always_ff @(posedge clk) begin
        if (o_resp_pop) begin
            o_data <= i_resp_data.flat;
        end
    end

endmodule

// File: src.f
design/bridge_user_pkg.sv
design/bridge_app_pkg.sv
design/sync_fifo.sv
design/user_request_fsm.sv
design/app_cmd_issuer.sv
design/dram_bridge_top.sv
verification/bridge_checker.sv
verification/tb_dram_bridge.sv

// File: verification/bridge_checker.sv
// Scoreboard for the DRAM bridge: mirrors user-side writes in a reference
// memory and checks each application command, write beat and read line.
`timescale 1ns/10ps

module bridge_checker (
    input  logic                                    clk,
    input  logic                                    rst_x_async,
    input  logic                                    i_rd_en,
    input  logic                                    i_wr_en,
    input  logic [bridge_user_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [bridge_user_pkg::USER_DATA_W-1:0] i_data,
    input  logic [bridge_user_pkg::USER_MASK_W-1:0] i_mask,
    input  logic                                    i_calib,
    input  logic                                    i_calib_sync,
    input  logic                                    i_busy,
    input  logic [bridge_app_pkg::APP_DATA_W-1:0]   i_line,
    input  logic                                    i_app_en,
    input  logic                                    i_app_rdy,
    input  logic [bridge_app_pkg::APP_CMD_W-1:0]    i_app_cmd,
    input  logic [bridge_app_pkg::APP_ADDR_W-1:0]   i_app_addr,
    input  logic                                    i_app_wdf_wren,
    input  logic                                    i_app_wdf_rdy,
    input  logic                                    i_app_wdf_end,
    input  logic [bridge_app_pkg::APP_DATA_W-1:0]   i_app_wdf_data,
    input  logic [bridge_app_pkg::APP_MASK_W-1:0]   i_app_wdf_mask,
    output int                                      o_checks,
    output int                                      o_errors,
    output int                                      o_outstanding
);

    import bridge_user_pkg::*;
    import bridge_app_pkg::*;

    localparam int CW = APP_CMD_W + APP_ADDR_W;
    localparam int WW = APP_DATA_W + APP_MASK_W;

    logic [USER_DATA_W-1:0] ref_mem [8][LANES];
    logic [CW-1:0]          exp_cmd [$];
    logic [WW-1:0]          exp_wd [$];
    logic [CW-1:0]          cmd_now;
    logic [WW-1:0]          wd_now;
    logic [CW-1:0]          held_cmd;
    logic [WW-1:0]          held_wd;
    logic                   en_held;
    logic                   wren_held;
    logic                   busy_fell;
    logic                   rd_pending;
    logic [2:0]             rd_idx;
    logic                   calib_d1;
    logic                   calib_d2;
    int                     calib_edges;
    app_line_u              exp_line;
    logic [APP_MASK_W-1:0]  exp_mask;

    task automatic check_value(input logic ok, input string what);
        o_checks++;
        if (!ok) begin
            o_errors++;
            $display("FAILED at %0d ns: %s", $time, what);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_x_async) begin
            en_held     = 1'b0;
            wren_held   = 1'b0;
            busy_fell   = 1'b0;
            rd_pending  = 1'b0;
            calib_d1    = 1'b0;
            calib_d2    = 1'b0;
            calib_edges = 0;
        end else begin
            // calibrate-done comes out two edges late
            check_value(i_calib_sync === calib_d2,
                $sformatf("calibrate-done sync %b expected %b", i_calib_sync, calib_d2));
            calib_d2 = calib_d1;
            calib_d1 = i_calib;

            // busy may only drop a few edges after calibration
            if (!busy_fell && !i_busy) begin
                busy_fell = 1'b1;
                check_value(calib_edges > 0 && calib_edges <= 3,
                    $sformatf("busy fell %0d edges after calibration", calib_edges));
            end
            if (!busy_fell && i_calib) begin
                calib_edges++;
            end

            // read finished on the previous edge
            if (rd_pending && !i_busy) begin
                for (int l = 0; l < LANES; l++) begin
                    exp_line.lane[l] = ref_mem[rd_idx][l];
                end
                check_value(i_line === exp_line.flat,
                    $sformatf("read line %0d got %h expected %h", rd_idx, i_line,
                        exp_line.flat));
                rd_pending = 1'b0;
            end

            // request taken at the user port, write wins
            if (!i_busy && (i_wr_en || i_rd_en)) begin
                exp_cmd.push_back({i_wr_en ? CMD_WRITE : CMD_READ, 2'b00, i_addr[26:4],
                    3'b000});
                if (i_wr_en) begin
                    for (int l = 0; l < LANES; l++) begin
                        exp_line.lane[l] = i_data;
                        exp_mask[l*LANE_MASK_W +: LANE_MASK_W] =
                            (l == int'(i_addr[3:2])) ? i_mask : '1;
                    end
                    exp_wd.push_back({exp_line.flat, exp_mask});
                    for (int b = 0; b < USER_MASK_W; b++) begin
                        if (!i_mask[b]) begin
                            ref_mem[i_addr[6:4]][i_addr[3:2]][b*8 +: 8] = i_data[b*8 +: 8];
                        end
                    end
                end else begin
                    rd_pending = 1'b1;
                    rd_idx     = i_addr[6:4];
                end
            end

            // strobes must hold until their ready is seen
            if (en_held) begin
                check_value(i_app_en && ({i_app_cmd, i_app_addr} === held_cmd),
                    "command dropped or changed before ready");
            end
            if (wren_held) begin
                check_value(i_app_wdf_wren && ({i_app_wdf_data, i_app_wdf_mask} === held_wd),
                    "write data dropped or changed before ready");
            end

            if (i_app_en && i_app_rdy) begin
                if (exp_cmd.size() == 0) begin
                    o_errors++;
                    $display("application command issued with no user request left over");
                end else begin
                    cmd_now = exp_cmd.pop_front();
                    check_value({i_app_cmd, i_app_addr} === cmd_now,
                        $sformatf("command %h expected %h", {i_app_cmd, i_app_addr}, cmd_now));
                end
            end
            if (i_app_wdf_wren && i_app_wdf_rdy) begin
                if (exp_wd.size() == 0) begin
                    o_errors++;
                    $display("write data beat issued with no user write left over");
                end else begin
                    wd_now = exp_wd.pop_front();
                    check_value(i_app_wdf_end && ({i_app_wdf_data, i_app_wdf_mask} === wd_now),
                        $sformatf("write beat %h expected %h",
                            {i_app_wdf_data, i_app_wdf_mask}, wd_now));
                end
            end

            en_held       = i_app_en && !i_app_rdy;
            held_cmd      = {i_app_cmd, i_app_addr};
            wren_held     = i_app_wdf_wren && !i_app_wdf_rdy;
            held_wd       = {i_app_wdf_data, i_app_wdf_mask};
            o_outstanding = exp_cmd.size() + exp_wd.size() + (rd_pending ? 1 : 0);
        end
    end

endmodule

// File: verification/tb_dram_bridge.sv
// Testbench for the DRAM bridge: random processor requests on one side and
// a behavioral DDR controller with random ready stalls on the other.
`timescale 1ns/10ps

module tb_dram_bridge;

    import bridge_user_pkg::*;
    import bridge_app_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_REQ    = 300;
    localparam int PREFILL    = 32;
    localparam int CW         = APP_CMD_W + APP_ADDR_W;
    localparam int WW         = APP_DATA_W + APP_MASK_W;

    logic                   clk = 1'b0;
    logic                   rst_x_async;
    logic                   i_rd_en;
    logic                   i_wr_en;
    logic [USER_ADDR_W-1:0] i_addr;
    logic [USER_DATA_W-1:0] i_data;
    logic [USER_MASK_W-1:0] i_mask;
    logic                   i_init_calib_complete;
    logic                   i_app_rdy = 1'b0;
    logic                   i_app_wdf_rdy = 1'b0;
    logic [APP_DATA_W-1:0]  i_app_rd_data = '0;
    logic                   i_app_rd_data_valid = 1'b0;
    logic                   o_busy;
    logic                   o_init_calib_complete;
    logic [APP_DATA_W-1:0]  o_data;
    logic                   o_app_en;
    logic [APP_CMD_W-1:0]   o_app_cmd;
    logic [APP_ADDR_W-1:0]  o_app_addr;
    logic                   o_app_wdf_wren;
    logic                   o_app_wdf_end;
    logic [APP_DATA_W-1:0]  o_app_wdf_data;
    logic [APP_MASK_W-1:0]  o_app_wdf_mask;

    // controller model draws from its own stream
    integer                 seed = 61;
    integer                 ctrl_seed = 61 * 3;
    logic [APP_DATA_W-1:0]  ctrl_mem [8];
    logic [CW-1:0]          pend_cmd [$];
    logic [WW-1:0]          pend_wd [$];
    logic [APP_DATA_W-1:0]  rd_line [$];
    int                     rd_due [$];
    int                     cycle = 0;
    int                     checks;
    int                     errors;
    int                     outstanding;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dram_bridge_top #(
        .QUEUE_DEPTH_LOG2 (2)
    ) u_dram_bridge_top (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_rd_en               (i_rd_en),
        .i_wr_en               (i_wr_en),
        .i_addr                (i_addr),
        .i_data                (i_data),
        .i_mask                (i_mask),
        .i_init_calib_complete (i_init_calib_complete),
        .i_app_rdy             (i_app_rdy),
        .i_app_wdf_rdy         (i_app_wdf_rdy),
        .i_app_rd_data         (i_app_rd_data),
        .i_app_rd_data_valid   (i_app_rd_data_valid),
        .o_busy                (o_busy),
        .o_init_calib_complete (o_init_calib_complete),
        .o_data                (o_data),
        .o_app_en              (o_app_en),
        .o_app_cmd             (o_app_cmd),
        .o_app_addr            (o_app_addr),
        .o_app_wdf_wren        (o_app_wdf_wren),
        .o_app_wdf_end         (o_app_wdf_end),
        .o_app_wdf_data        (o_app_wdf_data),
        .o_app_wdf_mask        (o_app_wdf_mask)
    );

    bridge_checker u_bridge_checker (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_rd_en        (i_rd_en),
        .i_wr_en        (i_wr_en),
        .i_addr         (i_addr),
        .i_data         (i_data),
        .i_mask         (i_mask),
        .i_calib        (i_init_calib_complete),
        .i_calib_sync   (o_init_calib_complete),
        .i_busy         (o_busy),
        .i_line         (o_data),
        .i_app_en       (o_app_en),
        .i_app_rdy      (i_app_rdy),
        .i_app_cmd      (o_app_cmd),
        .i_app_addr     (o_app_addr),
        .i_app_wdf_wren (o_app_wdf_wren),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .i_app_wdf_end  (o_app_wdf_end),
        .i_app_wdf_data (o_app_wdf_data),
        .i_app_wdf_mask (o_app_wdf_mask),
        .o_checks       (checks),
        .o_errors       (errors),
        .o_outstanding  (outstanding)
    );

    // commands in order, a write waits for its data beat
    task automatic serve_commands();
        logic [CW-1:0] cmd;
        logic [WW-1:0] wd;
        while (pend_cmd.size() > 0 &&
               (pend_cmd[0][CW-1 -: APP_CMD_W] == CMD_READ || pend_wd.size() > 0)) begin
            cmd = pend_cmd.pop_front();
            if (cmd[CW-1 -: APP_CMD_W] == CMD_READ) begin
                rd_line.push_back(ctrl_mem[cmd[5:3]]);
                rd_due.push_back(cycle + 1 + int'($unsigned($random(ctrl_seed)) % 6));
            end else begin
                wd = pend_wd.pop_front();
                for (int b = 0; b < APP_MASK_W; b++) begin
                    if (!wd[b]) begin
                        ctrl_mem[cmd[5:3]][b*8 +: 8] = wd[APP_MASK_W + b*8 +: 8];
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (o_app_en && i_app_rdy) begin
            pend_cmd.push_back({o_app_cmd, o_app_addr});
        end
        if (o_app_wdf_wren && i_app_wdf_rdy) begin
            pend_wd.push_back({o_app_wdf_data, o_app_wdf_mask});
        end
        serve_commands();
    end

    always @(negedge clk) begin
        i_app_rdy           = rst_x_async && (($random(ctrl_seed) & 3) != 0);
        i_app_wdf_rdy       = rst_x_async && (($random(ctrl_seed) & 3) != 0);
        i_app_rd_data_valid = 1'b0;
        if (rd_due.size() > 0 && rd_due[0] <= cycle) begin
            i_app_rd_data_valid = 1'b1;
            i_app_rd_data       = rd_line.pop_front();
            void'(rd_due.pop_front());
        end
    end

    // one request, held for a single cycle once the bridge is idle
    task automatic issue_request(input int n);
        logic [31:0] r;
        while (o_busy) begin
            @(negedge clk);
        end
        r      = $random(seed);
        i_data = $random(seed);
        if (n < PREFILL) begin
            i_wr_en = 1'b1;
            i_rd_en = 1'b0;
            i_mask  = 4'h0;
            i_addr  = {r[17:13], 20'd0, n[4:2], n[1:0], 2'b00};
        end else begin
            // mostly plain writes or reads, now and then both at once
            i_wr_en = (r[3:0] < 4'd7) || (r[3:0] > 4'd13);
            i_rd_en = (r[3:0] >= 4'd7);
            i_mask  = r[12:9];
            i_addr  = {r[17:13], 20'd0, r[6:4], r[8:7], 2'b00};
        end
        @(negedge clk);
        i_wr_en = 1'b0;
        i_rd_en = 1'b0;
        repeat (r[19:18]) @(negedge clk);
    endtask

    initial begin
        rst_x_async           = 1'b0;
        i_rd_en               = 1'b0;
        i_wr_en               = 1'b0;
        i_addr                = '0;
        i_data                = '0;
        i_mask                = '0;
        i_init_calib_complete = 1'b0;
        repeat (16) @(negedge clk);
        rst_x_async = 1'b1;
        repeat (4 + ($unsigned($random(seed)) % 24)) @(negedge clk);
        i_init_calib_complete = 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            issue_request(n);
        end
        while (o_busy || outstanding != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("requests: %0d  checks: %0d  errors: %0d", NUM_REQ, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_REQ * 40 * CLK_PERIOD);
        $display("timeout: requests still pending after %0d ns", NUM_REQ * 40 * CLK_PERIOD);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
